/* design/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define XLEN        32  // Data and PC width.
`define REG_ADDR_W  5
`define NUM_REGS    32
`define PC_STEP     4   // Instruction size in bytes.

`endif

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,  // ADD and SUB.
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // SRL and SRA.
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_alu_t;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } funct3_br_t;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // Selects SUB and SRA.

endpackage

`default_nettype wire

/* design/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        ALU_JAL,
        ALU_JALR,
        ALU_NOP
    } alu_op_t;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_J,
        OP2_IMM_U
    } op2_sel_t;

    // Link is pc plus one instruction.
    typedef enum logic {
        WB_ALU,
        WB_LINK
    } wb_sel_t;

endpackage

`default_nettype wire

/* design/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module inst_decode (
    input  logic                       inst_valid,
    input  logic [`XLEN-1:0]           inst,
    input  logic [`XLEN-1:0]           pc,
    input  logic [`XLEN-1:0]           rs1_data,
    input  logic [`XLEN-1:0]           rs2_data,
    input  logic                       ex_valid,
    input  logic                       ex_rf_wen,
    input  logic [`REG_ADDR_W-1:0]     ex_rd,
    output logic [`REG_ADDR_W-1:0]     rs1_addr,
    output logic [`REG_ADDR_W-1:0]     rs2_addr,
    output logic                       stall,
    output logic                       dec_valid,
    output core_ctrl_pkg::alu_op_t     dec_alu_op,
    output core_ctrl_pkg::wb_sel_t     dec_wb_sel,
    output logic                       dec_rf_wen,
    output logic [`REG_ADDR_W-1:0]     dec_rd,
    output logic [`XLEN-1:0]           dec_op1,
    output logic [`XLEN-1:0]           dec_op2,
    output logic [`XLEN-1:0]           dec_rs1_data,
    output logic [`XLEN-1:0]           dec_rs2_data,
    output logic [`XLEN-1:0]           dec_pc,
    output logic [`XLEN-1:0]           dec_imm_b
);

    rv_isa_pkg::opcode_t     opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic                    f7_zero;
    logic                    f7_alt;
    core_ctrl_pkg::op1_sel_t op1_sel;
    core_ctrl_pkg::op2_sel_t op2_sel;
    logic [`XLEN-1:0]        imm_i;
    logic [`XLEN-1:0]        imm_j;
    logic [`XLEN-1:0]        imm_u;

    assign opcode  = rv_isa_pkg::opcode_t'(inst[6:0]);
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_zero = (funct7 == 7'd0);
    assign f7_alt  = (funct7 == rv_isa_pkg::FUNCT7_ALT);

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // Sign-extended immediates.
    assign imm_i     = {{20{inst[31]}}, inst[31:20]};
    assign dec_imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u     = {inst[31:12], 12'd0};

    // ALU operation from funct3; alt picks SUB or SRA.
    function automatic core_ctrl_pkg::alu_op_t alu_from_f3(input logic [2:0] f3,
                                                           input logic alt);
        case (rv_isa_pkg::funct3_alu_t'(f3))
            rv_isa_pkg::F3_ADD:  return alt ? core_ctrl_pkg::ALU_SUB : core_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  return core_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  return core_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: return core_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  return core_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   return alt ? core_ctrl_pkg::ALU_SRA : core_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   return core_ctrl_pkg::ALU_OR;
            default:             return core_ctrl_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        // Anything not matched below passes as a NOP.
        dec_alu_op = core_ctrl_pkg::ALU_NOP;
        op1_sel    = core_ctrl_pkg::OP1_ZERO;
        op2_sel    = core_ctrl_pkg::OP2_RS2;
        dec_wb_sel = core_ctrl_pkg::WB_ALU;
        dec_rf_wen = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                if (f7_zero || (f7_alt && (funct3 == rv_isa_pkg::F3_ADD ||
                                           funct3 == rv_isa_pkg::F3_SR))) begin
                    dec_alu_op = alu_from_f3(funct3, f7_alt);
                    op1_sel    = core_ctrl_pkg::OP1_RS1;
                    dec_rf_wen = 1'b1;
                end
            end
            rv_isa_pkg::OP_IMM: begin
                // Only the shifts constrain funct7.
                if ((funct3 != rv_isa_pkg::F3_SLL && funct3 != rv_isa_pkg::F3_SR) ||
                    f7_zero || (f7_alt && funct3 == rv_isa_pkg::F3_SR)) begin
                    dec_alu_op = alu_from_f3(funct3, f7_alt && funct3 == rv_isa_pkg::F3_SR);
                    op1_sel    = core_ctrl_pkg::OP1_RS1;
                    op2_sel    = core_ctrl_pkg::OP2_IMM_I;
                    dec_rf_wen = 1'b1;
                end
            end
            rv_isa_pkg::BRANCH: begin
                op1_sel = core_ctrl_pkg::OP1_RS1;
                case (rv_isa_pkg::funct3_br_t'(funct3))
                    rv_isa_pkg::F3_BEQ:  dec_alu_op = core_ctrl_pkg::BR_BEQ;
                    rv_isa_pkg::F3_BNE:  dec_alu_op = core_ctrl_pkg::BR_BNE;
                    rv_isa_pkg::F3_BLT:  dec_alu_op = core_ctrl_pkg::BR_BLT;
                    rv_isa_pkg::F3_BGE:  dec_alu_op = core_ctrl_pkg::BR_BGE;
                    rv_isa_pkg::F3_BLTU: dec_alu_op = core_ctrl_pkg::BR_BLTU;
                    rv_isa_pkg::F3_BGEU: dec_alu_op = core_ctrl_pkg::BR_BGEU;
                    default:             dec_alu_op = core_ctrl_pkg::ALU_NOP;
                endcase
            end
            rv_isa_pkg::JAL: begin
                dec_alu_op = core_ctrl_pkg::ALU_JAL;
                op1_sel    = core_ctrl_pkg::OP1_PC;
                op2_sel    = core_ctrl_pkg::OP2_IMM_J;
                dec_wb_sel = core_ctrl_pkg::WB_LINK;
                dec_rf_wen = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                if (funct3 == 3'b000) begin
                    dec_alu_op = core_ctrl_pkg::ALU_JALR;
                    op1_sel    = core_ctrl_pkg::OP1_RS1;
                    op2_sel    = core_ctrl_pkg::OP2_IMM_I;
                    dec_wb_sel = core_ctrl_pkg::WB_LINK;
                    dec_rf_wen = 1'b1;
                end
            end
            rv_isa_pkg::LUI: begin
                dec_alu_op = core_ctrl_pkg::ALU_ADD;  // 0 + imm_u.
                op2_sel    = core_ctrl_pkg::OP2_IMM_U;
                dec_rf_wen = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                dec_alu_op = core_ctrl_pkg::ALU_ADD;
                op1_sel    = core_ctrl_pkg::OP1_PC;
                op2_sel    = core_ctrl_pkg::OP2_IMM_U;
                dec_rf_wen = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op1_sel)
            core_ctrl_pkg::OP1_RS1: dec_op1 = rs1_data;
            core_ctrl_pkg::OP1_PC:  dec_op1 = pc;
            default:                dec_op1 = '0;
        endcase
        case (op2_sel)
            core_ctrl_pkg::OP2_IMM_I: dec_op2 = imm_i;
            core_ctrl_pkg::OP2_IMM_J: dec_op2 = imm_j;
            core_ctrl_pkg::OP2_IMM_U: dec_op2 = imm_u;
            default:                  dec_op2 = rs2_data;
        endcase
    end

    // Read-after-write on the instruction held in execute; x0 never conflicts.
    assign stall = inst_valid && ex_valid && ex_rf_wen && (ex_rd != '0) &&
                   (ex_rd == rs1_addr || ex_rd == rs2_addr);

    assign dec_valid    = inst_valid && !stall;
    assign dec_rd       = inst[11:7];
    assign dec_rs1_data = rs1_data;
    assign dec_rs2_data = rs2_data;
    assign dec_pc       = pc;

endmodule

`default_nettype wire

/* design/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module alu_execute (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dec_valid,
    input  core_ctrl_pkg::alu_op_t     dec_alu_op,
    input  core_ctrl_pkg::wb_sel_t     dec_wb_sel,
    input  logic                       dec_rf_wen,
    input  logic [`REG_ADDR_W-1:0]     dec_rd,
    input  logic [`XLEN-1:0]           dec_op1,
    input  logic [`XLEN-1:0]           dec_op2,
    input  logic [`XLEN-1:0]           dec_rs1_data,
    input  logic [`XLEN-1:0]           dec_rs2_data,
    input  logic [`XLEN-1:0]           dec_pc,
    input  logic [`XLEN-1:0]           dec_imm_b,
    output logic                       ex_valid,
    output logic [`XLEN-1:0]           ex_pc,
    output logic                       ex_rf_wen,
    output logic [`REG_ADDR_W-1:0]     ex_rd,
    output logic [`XLEN-1:0]           ex_wb_data,
    output logic                       ex_br_taken,
    output logic [`XLEN-1:0]           ex_br_target
);

    core_ctrl_pkg::alu_op_t alu_op;
    core_ctrl_pkg::wb_sel_t wb_sel;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic [`XLEN-1:0]       rs1;
    logic [`XLEN-1:0]       rs2;
    logic [`XLEN-1:0]       imm_b;
    logic [`XLEN-1:0]       alu_out;
    logic [`XLEN-1:0]       sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            alu_op    <= dec_alu_op;
            wb_sel    <= dec_wb_sel;
            ex_rf_wen <= dec_rf_wen;
            ex_rd     <= dec_rd;
            op1       <= dec_op1;
            op2       <= dec_op2;
            rs1       <= dec_rs1_data;
            rs2       <= dec_rs2_data;
            ex_pc     <= dec_pc;
            imm_b     <= dec_imm_b;
        end
    end

    assign sum = op1 + op2;

    always_comb begin
        case (alu_op)
            core_ctrl_pkg::ALU_SUB:  alu_out = op1 - op2;
            core_ctrl_pkg::ALU_AND:  alu_out = op1 & op2;
            core_ctrl_pkg::ALU_OR:   alu_out = op1 | op2;
            core_ctrl_pkg::ALU_XOR:  alu_out = op1 ^ op2;
            core_ctrl_pkg::ALU_SLL:  alu_out = op1 << op2[4:0];
            core_ctrl_pkg::ALU_SRL:  alu_out = op1 >> op2[4:0];
            core_ctrl_pkg::ALU_SRA:  alu_out = $signed(op1) >>> op2[4:0];
            core_ctrl_pkg::ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            core_ctrl_pkg::ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, op1 < op2};
            core_ctrl_pkg::ALU_NOP:  alu_out = '0;
            default:                 alu_out = sum;  // ADD, jumps and branches.
        endcase
    end

    // Branch conditions compare the register values, not the operands.
    always_comb begin
        ex_br_target = ex_pc + imm_b;
        case (alu_op)
            core_ctrl_pkg::BR_BEQ:   ex_br_taken = (rs1 == rs2);
            core_ctrl_pkg::BR_BNE:   ex_br_taken = (rs1 != rs2);
            core_ctrl_pkg::BR_BLT:   ex_br_taken = ($signed(rs1) < $signed(rs2));
            core_ctrl_pkg::BR_BGE:   ex_br_taken = ($signed(rs1) >= $signed(rs2));
            core_ctrl_pkg::BR_BLTU:  ex_br_taken = (rs1 < rs2);
            core_ctrl_pkg::BR_BGEU:  ex_br_taken = (rs1 >= rs2);
            core_ctrl_pkg::ALU_JAL: begin
                ex_br_taken  = 1'b1;
                ex_br_target = sum;
            end
            core_ctrl_pkg::ALU_JALR: begin
                ex_br_taken  = 1'b1;
                ex_br_target = {sum[`XLEN-1:1], 1'b0};
            end
            default:                 ex_br_taken = 1'b0;
        endcase
    end

    assign ex_wb_data = (wb_sel == core_ctrl_pkg::WB_LINK) ? ex_pc + `XLEN'(`PC_STEP) : alu_out;

endmodule

`default_nettype wire

/* design/result_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module result_regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ex_valid,
    input  logic [`XLEN-1:0]           ex_pc,
    input  logic                       ex_rf_wen,
    input  logic [`REG_ADDR_W-1:0]     ex_rd,
    input  logic [`XLEN-1:0]           ex_wb_data,
    input  logic                       ex_br_taken,
    input  logic [`XLEN-1:0]           ex_br_target,
    input  logic [`REG_ADDR_W-1:0]     rs1_addr,
    input  logic [`REG_ADDR_W-1:0]     rs2_addr,
    output logic [`XLEN-1:0]           rs1_data,
    output logic [`XLEN-1:0]           rs2_data,
    output logic                       retire_valid,
    output logic [`XLEN-1:0]           retire_pc,
    output logic                       retire_rf_wen,
    output logic [`REG_ADDR_W-1:0]     retire_rd,
    output logic [`XLEN-1:0]           retire_data,
    output logic                       retire_br_taken,
    output logic [`XLEN-1:0]           retire_br_target
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // Written on the same edge that raises retire_valid.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_valid && ex_rf_wen && ex_rd != '0) begin
            regs[ex_rd] <= ex_wb_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc        <= ex_pc;
        retire_rf_wen    <= ex_rf_wen;
        retire_rd        <= ex_rd;
        retire_data      <= ex_wb_data;
        retire_br_taken  <= ex_br_taken;
        retire_br_target <= ex_br_target;
    end

endmodule

`default_nettype wire

/* design/int_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module int_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inst_valid,
    input  logic [`XLEN-1:0]           inst,
    input  logic [`XLEN-1:0]           pc,
    output logic                       stall,
    output logic                       retire_valid,
    output logic [`XLEN-1:0]           retire_pc,
    output logic                       retire_rf_wen,
    output logic [`REG_ADDR_W-1:0]     retire_rd,
    output logic [`XLEN-1:0]           retire_data,
    output logic                       retire_br_taken,
    output logic [`XLEN-1:0]           retire_br_target
);

    logic [`REG_ADDR_W-1:0]  rs1_addr;
    logic [`REG_ADDR_W-1:0]  rs2_addr;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    logic                    dec_valid;
    core_ctrl_pkg::alu_op_t  dec_alu_op;
    core_ctrl_pkg::wb_sel_t  dec_wb_sel;
    logic                    dec_rf_wen;
    logic [`REG_ADDR_W-1:0]  dec_rd;
    logic [`XLEN-1:0]        dec_op1;
    logic [`XLEN-1:0]        dec_op2;
    logic [`XLEN-1:0]        dec_rs1_data;
    logic [`XLEN-1:0]        dec_rs2_data;
    logic [`XLEN-1:0]        dec_pc;
    logic [`XLEN-1:0]        dec_imm_b;
    logic                    ex_valid;
    logic [`XLEN-1:0]        ex_pc;
    logic                    ex_rf_wen;
    logic [`REG_ADDR_W-1:0]  ex_rd;
    logic [`XLEN-1:0]        ex_wb_data;
    logic                    ex_br_taken;
    logic [`XLEN-1:0]        ex_br_target;

    inst_decode i_decode (
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .ex_valid     (ex_valid),
        .ex_rf_wen    (ex_rf_wen),
        .ex_rd        (ex_rd),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .stall        (stall),
        .dec_valid    (dec_valid),
        .dec_alu_op   (dec_alu_op),
        .dec_wb_sel   (dec_wb_sel),
        .dec_rf_wen   (dec_rf_wen),
        .dec_rd       (dec_rd),
        .dec_op1      (dec_op1),
        .dec_op2      (dec_op2),
        .dec_rs1_data (dec_rs1_data),
        .dec_rs2_data (dec_rs2_data),
        .dec_pc       (dec_pc),
        .dec_imm_b    (dec_imm_b)
    );

    alu_execute i_execute (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_alu_op   (dec_alu_op),
        .dec_wb_sel   (dec_wb_sel),
        .dec_rf_wen   (dec_rf_wen),
        .dec_rd       (dec_rd),
        .dec_op1      (dec_op1),
        .dec_op2      (dec_op2),
        .dec_rs1_data (dec_rs1_data),
        .dec_rs2_data (dec_rs2_data),
        .dec_pc       (dec_pc),
        .dec_imm_b    (dec_imm_b),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .ex_rf_wen    (ex_rf_wen),
        .ex_rd        (ex_rd),
        .ex_wb_data   (ex_wb_data),
        .ex_br_taken  (ex_br_taken),
        .ex_br_target (ex_br_target)
    );

    result_regfile i_result (
        .clk              (clk),
        .rst              (rst),
        .ex_valid         (ex_valid),
        .ex_pc            (ex_pc),
        .ex_rf_wen        (ex_rf_wen),
        .ex_rd            (ex_rd),
        .ex_wb_data       (ex_wb_data),
        .ex_br_taken      (ex_br_taken),
        .ex_br_target     (ex_br_target),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_rf_wen    (retire_rf_wen),
        .retire_rd        (retire_rd),
        .retire_data      (retire_data),
        .retire_br_taken  (retire_br_taken),
        .retire_br_target (retire_br_target)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tb_int_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_int_core;

    logic                   clk;
    logic                   rst;
    logic                   inst_valid;
    logic [`XLEN-1:0]       inst;
    logic [`XLEN-1:0]       pc;
    logic                   stall;
    logic                   retire_valid;
    logic [`XLEN-1:0]       retire_pc;
    logic                   retire_rf_wen;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;
    logic                   retire_br_taken;
    logic [`XLEN-1:0]       retire_br_target;

    logic [31:0] model [`NUM_REGS];  // Expected register contents.
    logic [31:0] rng;
    int          checks;
    int          errors;

    logic [2:0] rr_f3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic       rr_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    logic [2:0] br_f3  [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0] br_a  [3]  = '{32'h0000_1234, 32'hFFFF_FFF0, 32'h0000_0005};
    logic [31:0] br_b  [3]  = '{32'h0000_1234, 32'h0000_0005, 32'hFFFF_FFF0};

    tb_clock i_clock (.clk(clk), .rst(rst));

    int_core i_dut (
        .clk              (clk),
        .rst              (rst),
        .inst_valid       (inst_valid),
        .inst             (inst),
        .pc               (pc),
        .stall            (stall),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_rf_wen    (retire_rf_wen),
        .retire_rd        (retire_rd),
        .retire_data      (retire_data),
        .retire_br_taken  (retire_br_taken),
        .retire_br_target (retire_br_target)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] i);
        return {{20{i[11]}}, i};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input rv_isa_pkg::opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH};
    endfunction

    // RV32I arithmetic as the ISA defines it.
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic fail_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Presents one instruction until accepted; returns the stall cycles seen.
    task automatic issue(input logic [31:0] word, input logic [31:0] addr, output int stalls);
        stalls = 0;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
        pc         = addr;
        #1;
        while (stall) begin
            stalls++;
            if (stalls > 20) fail_timeout("stall never released");
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic wait_retire(input string name, input int exp_lat);
        int lat;
        @(negedge clk);
        inst_valid = 1'b0;
        lat = 1;
        while (!retire_valid) begin
            lat++;
            if (lat > 10) fail_timeout({"no retire in ", name});
            @(negedge clk);
        end
        check({name, " latency"}, 32'(exp_lat), 32'(lat));
    endtask

    task automatic run(input string name, input logic [31:0] word, input logic [31:0] addr);
        int s;
        issue(word, addr, s);
        check({name, " stall"}, 32'd0, 32'(s));
        wait_retire(name, 2);
        check({name, " pc"}, addr, retire_pc);
    endtask

    task automatic exec_check(input string name, input logic [31:0] word,
                              input logic [31:0] addr, input logic [4:0] rd,
                              input logic [31:0] exp);
        run(name, word, addr);
        check({name, " wen"}, 32'd1, {31'd0, retire_rf_wen});
        check({name, " rd"}, {27'd0, rd}, {27'd0, retire_rd});
        check({name, " data"}, exp, retire_data);
        if (rd != 5'd0) model[rd] = exp;
    endtask

    // LUI plus ADDI, with the upper part rounded for the signed low part.
    task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) & 32'hFFFF_F000;
        exec_check("set_lui", {upper[31:12], rd, rv_isa_pkg::LUI}, 32'h100, rd, upper);
        exec_check("set_addi", enc_i(v[11:0], rd, 3'd0, rd, rv_isa_pkg::OP_IMM), 32'h104, rd, v);
    endtask

    task automatic test_reset;
        int n;
        n = 0;
        @(negedge clk);
        #1;
        while (rst) begin
            check("reset retire_valid", 32'd0, {31'd0, retire_valid});
            check("reset stall", 32'd0, {31'd0, stall});
            n++;
            if (n > 50) fail_timeout("reset never released");
            @(negedge clk);
            #1;
        end
        repeat (3) begin
            @(negedge clk);
            check("post reset retire_valid", 32'd0, {31'd0, retire_valid});
            check("post reset stall", 32'd0, {31'd0, stall});
        end
    endtask

    task automatic test_immediates;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] addr;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        for (int k = 0; k < 3; k++) begin
            rng = xorshift(rng);
            rd  = (rng[4:0] == 5'd0) ? 5'd1 : rng[4:0];
            exec_check("lui", {rng[31:12], rd, rv_isa_pkg::LUI}, 32'h200, rd, {rng[31:12], 12'd0});
            a    = rng;
            rng  = xorshift(rng);
            addr = {rng[31:2], 2'b00};
            exec_check("auipc", {a[31:12], rd, rv_isa_pkg::AUIPC}, addr, rd,
                       addr + {a[31:12], 12'd0});
            rng = xorshift(rng);
            set_reg(5'd9, rng);
            for (int i = 0; i < 9; i++) begin
                f3  = (i < 8) ? 3'(i) : 3'd5;
                alt = (i == 8);
                rng = xorshift(rng);
                imm = rng[11:0];
                if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'd0, rng[4:0]};
                exec_check($sformatf("imm_op f3=%0d", f3),
                           enc_i(imm, 5'd9, f3, 5'd10, rv_isa_pkg::OP_IMM), 32'h300,
                           5'd10, alu_ref(f3, alt, model[9], sext12(imm)));
            end
        end
        exec_check("x0 write", enc_i(12'h123, 5'd0, 3'd0, 5'd0, rv_isa_pkg::OP_IMM),
                   32'h400, 5'd0, 32'h123);
        exec_check("x0 read", enc_i(12'd0, 5'd0, 3'd0, 5'd10, rv_isa_pkg::OP_IMM),
                   32'h404, 5'd10, 32'd0);
    endtask

    task automatic test_reg_reg;
        for (int i = 0; i < 10; i++) begin
            rng = xorshift(rng);
            set_reg(5'd1, rng);
            rng = xorshift(rng);
            set_reg(5'd2, rng);
            exec_check($sformatf("reg_op %0d", i),
                       enc_r(rr_alt[i] ? rv_isa_pkg::FUNCT7_ALT : 7'd0, 5'd2, 5'd1, rr_f3[i], 5'd3),
                       32'h500, 5'd3, alu_ref(rr_f3[i], rr_alt[i], model[1], model[2]));
        end
    endtask

    task automatic test_hazard;
        int s;
        rng = xorshift(rng);
        issue(enc_i(rng[11:0], 5'd0, 3'd0, 5'd5, rv_isa_pkg::OP_IMM), 32'h600, s);
        model[5] = sext12(rng[11:0]);
        issue(enc_r(7'd0, 5'd5, 5'd5, 3'd0, 5'd6), 32'h604, s);
        check("hazard stall cycles", 32'd1, 32'(s));
        wait_retire("hazard", 2);
        check("hazard data", model[5] + model[5], retire_data);
        model[6] = model[5] + model[5];
        // Independent pair back to back.
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd7, rv_isa_pkg::OP_IMM), 32'h608, s);
        issue(enc_r(7'd0, 5'd0, 5'd5, 3'd0, 5'd8), 32'h60C, s);
        check("independent stall cycles", 32'd0, 32'(s));
        wait_retire("independent first", 1);
        check("independent first data", 32'd1, retire_data);
        wait_retire("independent second", 1);
        check("independent second data", model[5], retire_data);
        model[7] = 32'd1;
        model[8] = model[5];
    endtask

    task automatic test_branches;
        logic [12:0] imm;
        logic [20:0] jimm;
        logic [31:0] addr;
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin
                set_reg(5'd1, br_a[p]);
                set_reg(5'd2, br_b[p]);
                rng  = xorshift(rng);
                imm  = {rng[12:1], 1'b0};
                addr = {rng[31:14], 12'd0, 2'b00};
                run("branch", enc_b(imm, 5'd2, 5'd1, br_f3[i]), addr);
                check($sformatf("branch f3=%0d taken", br_f3[i]),
                      {31'd0, branch_ref(br_f3[i], br_a[p], br_b[p])}, {31'd0, retire_br_taken});
                check("branch target", addr + {{19{imm[12]}}, imm}, retire_br_target);
                check("branch wen", 32'd0, {31'd0, retire_rf_wen});
            end
        end
        rng  = xorshift(rng);
        jimm = {rng[20:1], 1'b0};
        addr = {rng[31:22], 20'd0, 2'b00};
        exec_check("jal", {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd4, rv_isa_pkg::JAL},
                   addr, 5'd4, addr + 32'(`PC_STEP));
        check("jal target", addr + {{11{jimm[20]}}, jimm}, retire_br_target);
        rng = xorshift(rng);
        set_reg(5'd5, rng);
        rng = xorshift(rng);
        exec_check("jalr", enc_i(rng[11:0], 5'd5, 3'd0, 5'd4, rv_isa_pkg::JALR),
                   32'h700, 5'd4, 32'h704);
        check("jalr target", (model[5] + sext12(rng[11:0])) & 32'hFFFF_FFFE, retire_br_target);
        check("jalr taken", 32'd1, {31'd0, retire_br_taken});
    endtask

    task automatic test_unknown;
        logic [31:0] word;
        rng  = xorshift(rng);
        word = {rng[31:7], 7'b1111111};
        run("unknown", word, 32'h800);
        check("unknown wen", 32'd0, {31'd0, retire_rf_wen});
        check("unknown taken", 32'd0, {31'd0, retire_br_taken});
        exec_check("unknown readback", enc_i(12'd0, word[11:7], 3'd0, 5'd11, rv_isa_pkg::OP_IMM),
                   32'h804, 5'd11, model[word[11:7]]);
    endtask

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        rng        = 32'd59047;
        checks     = 0;
        errors     = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model[i] = '0;
        end
        test_reset();
        test_immediates();
        test_reg_reg();
        test_hazard();
        test_branches();
        test_unknown();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/inst_decode.sv
design/alu_execute.sv
design/result_regfile.sv
design/int_core.sv
sim/tb_clock.sv
sim/tb_int_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_int_core -f build.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
